// ==== build.f ====
+incdir+include
hdl/core_pkg.sv
hdl/bridge_read_mux.sv
hdl/kbd_mouse_sched.sv
hdl/cpu_phase_gen.sv
hdl/video_encoder.sv
hdl/core_top.sv
bench/tb_core_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core glue testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_core_top -f build.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_core_top)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== bench/tb_core_top.sv ====
// directed testbench for the core glue top level
// inputs change on the rising clk_114 edge, outputs are sampled on the falling edge
// c1 runs with a 16 cycle period once started, same as the phase divider

`timescale 1ns/1ns

module tb_core_top
	import core_pkg::*;
();

	logic           clk_114 = 1'b0;
	logic           cpu_rst;
	data32_t        bridge_addr;
	bridge_rd_src_t bridge_rd_src;
	data32_t        bridge_rd_data;
	kms_src_t       kms_src;
	kms_out_t       kms_out;
	logic           c1;
	logic           ram_ready;
	logic           ram_sel;
	cpucfg_t        cpucfg;
	logic           cyc;
	logic           cpu_ph1;
	logic           cpu_ph2;
	logic           ram_cs;
	logic           pix_en;
	video_in_t      video_in;
	video_out_t     video_out;

	logic        c1_run;    // c1 generator on
	logic [3:0]  c1_cnt;
	logic [31:0] lfsr;
	int          errors;
	int          checks;

	core_top core_top_inst (.*);

	always #20 clk_114 = ~clk_114;   // 40 ns period

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;   // galois taps 32,22,2,1
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          k;
		r = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// every rising edge goes through here so c1 keeps its period
	task automatic step_clk();
		@(posedge clk_114);
		if (c1_run) begin
			c1     <= (c1_cnt < 4'd8);   // 8 high, 8 low
			c1_cnt <= c1_cnt + 4'd1;
		end
	endtask

	// cpu_rst low for two cycles, phase outputs must stay low meanwhile
	task automatic apply_reset();
		int i;
		step_clk();
		cpu_rst <= 1'b0;
		for (i = 0; i < 2; i++) begin
			step_clk();
			if (i == 1) begin
				cpu_rst <= 1'b1;
			end
			@(negedge clk_114);
			check(32'(cyc), 32'd0, "cyc in reset");
			check(32'(cpu_ph1), 32'd0, "cpu_ph1 in reset");
			check(32'(cpu_ph2), 32'd0, "cpu_ph2 in reset");
		end
	endtask

	//////////////////////////////////////////////////
	// bridge decode
	//////////////////////////////////////////////////

	task automatic read_addr(input data32_t addr, input int sel);
		data32_t exp;
		step_clk();
		bridge_addr <= addr;
		@(negedge clk_114);
		case (sel)
			1:       exp = bridge_rd_src.fpga;
			2:       exp = bridge_rd_src.mcu;
			3:       exp = bridge_rd_src.cmd;
			default: exp = '0;   // unmapped
		endcase
		check(bridge_rd_data, exp, $sformatf("bridge read at %h", addr));
	endtask

	task automatic test_bridge();
		int i;
		for (i = 0; i < 4; i++) begin
			step_clk();
			bridge_rd_src.fpga <= rand_bits(32);
			bridge_rd_src.mcu  <= rand_bits(32);
			bridge_rd_src.cmd  <= rand_bits(32);
			read_addr({8'h10, 24'(rand_bits(24))}, 1);
			read_addr({16'h8000, 16'(rand_bits(16))}, 2);
			read_addr({8'hF8, 24'(rand_bits(24))}, 3);
			read_addr({4'h2, 28'(rand_bits(28))}, 0);
		end
		// window edges
		read_addr(32'h1000_0000, 1);
		read_addr(32'h10FF_FFFF, 1);
		read_addr(32'h0FFF_FFFF, 0);
		read_addr(32'h1100_0000, 0);
		read_addr(32'h8000_0000, 2);
		read_addr(32'h8000_FFFF, 2);
		read_addr(32'h7FFF_FFFF, 0);
		read_addr(32'h8001_0000, 0);
		read_addr(32'hF800_0000, 3);
		read_addr(32'hF8FF_FFFF, 3);
		read_addr(32'hF7FF_FFFF, 0);
		read_addr(32'hF900_0000, 0);
		read_addr(32'h0000_0000, 0);
	endtask

	//////////////////////////////////////////////////
	// keyboard/mouse scheduler
	//////////////////////////////////////////////////

	task automatic test_scheduler();
		int         i;
		logic [1:0] slot;
		logic [7:0] exp_data;
		logic       exp_level;
		step_clk();
		kms_src.cont3_key  <= rand_bits(32);
		kms_src.cont3_joy  <= rand_bits(32);
		kms_src.cont4_joy  <= rand_bits(32);
		kms_src.cont4_trig <= 16'(rand_bits(16));
		apply_reset();
		check(32'(kms_out), 32'd0, "kms reset state");
		for (i = 0; i < 32; i++) begin
			step_clk();
			@(negedge clk_114);
			slot = 2'(i / 2 + 1);   // 1,1,2,2,3,3,0,0,...
			case (slot)
				2'd1: begin
					exp_data  = kms_src.cont4_trig[7:0];
					exp_level = 1'b0;
				end
				2'd2: begin
					exp_data  = kms_src.cont3_joy[31:24];
					exp_level = 1'b1;
				end
				2'd3: begin
					exp_data  = kms_src.cont3_key[7:0];
					exp_level = 1'b0;
				end
				default: begin
					exp_data  = kms_src.cont4_joy[7:0];
					exp_level = 1'b1;
				end
			endcase
			check(32'(kms_out.kms_type), 32'(slot), $sformatf("kms type, sample %0d", i));
			check(32'(kms_out.data), 32'(exp_data), $sformatf("kms data, sample %0d", i));
			check(32'(kms_out.level), 32'(exp_level), $sformatf("kms level, sample %0d", i));
		end
	endtask

	//////////////////////////////////////////////////
	// cpu phases and ram select
	//////////////////////////////////////////////////

	task automatic wait_ph2_rise();
		int   n;
		logic prev;
		logic found;
		found = 1'b0;
		prev  = cpu_ph2;
		for (n = 0; n < 64 && !found; n++) begin
			step_clk();
			@(negedge clk_114);
			found = cpu_ph2 & ~prev;
			prev  = cpu_ph2;
		end
		if (!found) begin
			errors++;
			$display("timeout at %0t ns: cpu_ph2 never rose after c1 started", $time);
		end
	endtask

	task automatic test_phases();
		int i;
		int n1;
		int n2;
		int nc;
		int run1;
		int run2;
		int last_cyc;
		c1_run = 1'b1;
		apply_reset();
		wait_ph2_rise();   // divider now locked to c1
		n1       = 0;
		n2       = 0;
		nc       = 0;
		run1     = 0;
		run2     = 0;
		last_cyc = -1;
		for (i = 0; i < 64; i++) begin
			if (i > 0) begin
				step_clk();
				@(negedge clk_114);
			end
			check(32'(cpu_ph1 & cpu_ph2), 32'd0, "cpu phases overlap");
			if (cyc) begin
				if (last_cyc >= 0) begin
					check(32'(i - last_cyc), 32'd4, "cyc spacing");
				end
				last_cyc = i;
				nc++;
			end
			if (cpu_ph1) begin
				n1++;
				run1++;
			end else begin
				if (run1 != 0) check(32'(run1), 32'd4, "cpu_ph1 high time");
				run1 = 0;
			end
			if (cpu_ph2) begin
				n2++;
				run2++;
			end else begin
				if (run2 != 0) check(32'(run2), 32'd4, "cpu_ph2 high time");
				run2 = 0;
			end
		end
		check(nc, 32'd16, "cyc count over 64 cycles");
		check(n1, 32'd16, "cpu_ph1 count over 64 cycles");
		check(n2, 32'd16, "cpu_ph2 count over 64 cycles");
	endtask

	// ram_cs one cycle after sel/ready/cpu type/cyc, each combo held over a cyc
	task automatic test_ram_select();
		int         i;
		int         drops;
		logic [2:0] combo;
		logic       exp;
		logic       exp_cyc;
		logic       sel_q;
		logic       have_exp;
		have_exp = 1'b0;
		exp      = 1'b0;
		sel_q    = 1'b0;
		drops    = 0;
		for (i = 0; i < 34; i++) begin
			combo = 3'(i / 4);
			step_clk();
			ram_sel   <= combo[0];
			ram_ready <= combo[1];
			cpucfg    <= {combo[2], combo[0]};
			@(negedge clk_114);
			// divider locked, cyc lands on every fourth c1 count
			exp_cyc = (c1_cnt[1:0] == 2'd0);
			check(32'(cyc), 32'(exp_cyc), $sformatf("cyc position, step %0d", i));
			if (have_exp) begin
				check(32'(ram_cs), 32'(exp), $sformatf("ram_cs, step %0d", i));
				if (sel_q && !ram_cs) begin
					drops++;   // selected cs dropped on a fast cycle
				end
			end
			exp      = ram_sel & ~(ram_ready & exp_cyc & cpucfg[1]);
			sel_q    = ram_sel;
			have_exp = 1'b1;
		end
		check(32'(drops > 0), 32'd1, "ram_cs drop seen");
	endtask

	//////////////////////////////////////////////////
	// video encoder
	//////////////////////////////////////////////////

	function automatic video_in_t vin(input logic hs, input logic vs, input logic hblank,
		input logic lace, input logic field1, input res_t res, input rgb_t px);
		video_in_t v;
		v.r      = px[23:16];
		v.g      = px[15:8];
		v.b      = px[7:0];
		v.hs     = hs;
		v.vs     = vs;
		v.hblank = hblank;
		v.lace   = lace;
		v.field1 = field1;
		v.res    = res;
		return v;
	endfunction

	function automatic video_out_t vout(input rgb_t rgb, input logic de, input logic vs,
		input logic hs);
		video_out_t o;
		o.rgb = rgb;
		o.de  = de;
		o.vs  = vs;
		o.hs  = hs;
		return o;
	endfunction

	// one enabled sample, then three idle cycles with junk on video_in
	task automatic video_step(input video_in_t v, input video_out_t exp, input string what);
		int i;
		step_clk();
		video_in <= v;
		pix_en   <= 1'b1;
		step_clk();
		pix_en <= 1'b0;
		@(negedge clk_114);
		check(32'(video_out), 32'(exp), what);
		for (i = 0; i < 2; i++) begin
			step_clk();
			video_in <= 31'(rand_bits(31));
			@(negedge clk_114);
			check(32'(video_out), 32'(exp), {what, ", hold"});
		end
	endtask

	task automatic test_video();
		int   k;
		rgb_t px;
		res_t res;
		logic lace;
		logic field1;
		apply_reset();
		px = 24'(rand_bits(24));
		// histories are zero after reset, so blanking starts with an hblank rise
		video_step(vin(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0, px),
			vout('0, 1'b0, 1'b0, 1'b0), "res 0 code");
		for (k = 3; k >= 1; k--) begin
			res = 2'(k);
			px  = 24'(rand_bits(24));
			video_step(vin(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, res, px),
				vout(px, 1'b1, 1'b0, 1'b0), "active pixel");
			// code is the res value in bits 17:16
			video_step(vin(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, res, px),
				vout({6'd0, res, 16'd0}, 1'b0, 1'b0, 1'b0), $sformatf("res %0d code", k));
			video_step(vin(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, res, px),
				vout('0, 1'b0, 1'b0, 1'b0), "hblank held");
		end
		px = 24'(rand_bits(24));
		video_step(vin(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, px),
			vout(px, 1'b1, 1'b0, 1'b1), "hs fall in active video");
		video_step(vin(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, px),
			vout(px, 1'b1, 1'b0, 1'b0), "hs held low");
		for (k = 0; k < 4; k++) begin
			lace   = k[0];
			field1 = k[1];
			video_step(vin(1'b1, 1'b0, 1'b1, lace, field1, 2'd0, px),
				vout({21'd0, lace & field1, lace, 1'b0}, 1'b0, 1'b1, 1'b0), "vs flag word");
			video_step(vin(1'b1, 1'b1, 1'b1, lace, field1, 2'd0, px),
				vout('0, 1'b0, 1'b0, 1'b0), "vs pulse ends");
		end
		// vs fall wins over active video
		video_step(vin(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 2'd0, px),
			vout(24'h000006, 1'b0, 1'b1, 1'b0), "vs fall over active video");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		cpu_rst       <= 1'b0;
		bridge_addr   <= '0;
		bridge_rd_src <= '0;
		kms_src       <= '0;
		c1            <= 1'b0;
		ram_ready     <= 1'b0;
		ram_sel       <= 1'b0;
		cpucfg        <= '0;
		pix_en        <= 1'b0;
		video_in      <= '0;
		c1_cnt        <= '0;
		c1_run = 1'b0;
		lfsr   = 32'h3f125cb3;
		errors = 0;
		checks = 0;
		apply_reset();
		test_bridge();
		test_scheduler();
		test_phases();
		test_ram_select();
		test_video();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== hdl/core_top.sv ====
// glue top level, external cores live outside and connect through the ports
// single clock clk_114, cpu_rst is synchronous and active low everywhere
// the four blocks are independent of each other

`timescale 1ns/1ns

module core_top
	import core_pkg::*;
(
	input  logic           clk_114,
	input  logic           cpu_rst,
	// bridge read path
	input  data32_t        bridge_addr,
	input  bridge_rd_src_t bridge_rd_src,
	output data32_t        bridge_rd_data,
	// keyboard/mouse port
	input  kms_src_t       kms_src,
	output kms_out_t       kms_out,
	// cpu timing
	input  logic           c1,
	input  logic           ram_ready,
	input  logic           ram_sel,
	input  cpucfg_t        cpucfg,
	output logic           cyc,
	output logic           cpu_ph1,
	output logic           cpu_ph2,
	output logic           ram_cs,
	// video to scaler
	input  logic           pix_en,
	input  video_in_t      video_in,
	output video_out_t     video_out
);

	bridge_read_mux bridge_read_mux_inst (
		.bridge_addr    (bridge_addr),
		.bridge_rd_src  (bridge_rd_src),
		.bridge_rd_data (bridge_rd_data)
	);

	kbd_mouse_sched kbd_mouse_sched_inst (
		.clk_114 (clk_114),
		.cpu_rst (cpu_rst),
		.kms_src (kms_src),
		.kms_out (kms_out)
	);

	cpu_phase_gen cpu_phase_gen_inst (
		.clk_114   (clk_114),
		.cpu_rst   (cpu_rst),
		.c1        (c1),
		.ram_ready (ram_ready),
		.ram_sel   (ram_sel),
		.cpucfg    (cpucfg),
		.cyc       (cyc),
		.cpu_ph1   (cpu_ph1),
		.cpu_ph2   (cpu_ph2),
		.ram_cs    (ram_cs)
	);

	video_encoder video_encoder_inst (
		.clk_114   (clk_114),
		.cpu_rst   (cpu_rst),
		.pix_en    (pix_en),    // pixel enable in the clk_114 domain
		.video_in  (video_in),
		.video_out (video_out)
	);

endmodule

// ==== hdl/video_encoder.sv ====
// everything updates on pix_en cycles only and holds in between
// hs/vs inputs are active low, output pulses last one enabled cycle
// interlace flags ride on rgb during the vs pulse, res code on hblank rise

`timescale 1ns/1ns

`include "core_params.svh"

module video_encoder
	import core_pkg::*;
(
	input  logic       clk_114,
	input  logic       cpu_rst,
	input  logic       pix_en,
	input  video_in_t  video_in,
	output video_out_t video_out
);

	video_out_t out_q;
	video_out_t out_next;
	logic       hs_d;        // previous enabled samples
	logic       vs_d;
	logic       hblank_d;
	logic       hs_fall;
	logic       vs_fall;
	logic       hblank_rise;
	rgb_t       res_word;
	rgb_t       flag_word;

	assign hs_fall     = hs_d & ~video_in.hs;
	assign vs_fall     = vs_d & ~video_in.vs;
	assign hblank_rise = video_in.hblank & ~hblank_d;

	// bit 1 lace, bit 2 lace and field1
	assign flag_word = {{(`RGB_W-3){1'b0}}, video_in.lace & video_in.field1,
		video_in.lace, 1'b0};

	always_comb begin
		case (video_in.res)
			2'd3:    res_word = `RES_CODE_HI;
			2'd2:    res_word = `RES_CODE_MID;
			2'd1:    res_word = `RES_CODE_LO;
			default: res_word = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// output word priority
	//////////////////////////////////////////////////

	always_comb begin
		out_next    = '0;
		out_next.hs = hs_fall;   // independent of the rules below
		if (vs_fall) begin
			out_next.vs  = 1'b1;
			out_next.rgb = flag_word;
		end else if (!video_in.hblank) begin
			out_next.de  = 1'b1;
			out_next.rgb = {video_in.r, video_in.g, video_in.b};
		end else if (hblank_rise) begin
			out_next.rgb = res_word;
		end
	end

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_114) begin
		if (!cpu_rst) begin
			out_q    <= '0;
			hs_d     <= 1'b0;
			vs_d     <= 1'b0;
			hblank_d <= 1'b0;
		end else if (pix_en) begin
			out_q    <= out_next;
			hs_d     <= video_in.hs;
			vs_d     <= video_in.vs;
			hblank_d <= video_in.hblank;
		end
	end

	assign video_out = out_q;

endmodule

// ==== hdl/cpu_phase_gen.sv ====
// divider on clk_114, relocked to the chipset c1 strobe on every rising edge
// divider and ram_cs are not reset, they settle after the first c1 edge
// cyc is one cycle in four, ph1/ph2 are 4 of 16 cycles and never overlap

`timescale 1ns/1ns

`include "core_params.svh"

module cpu_phase_gen
	import core_pkg::*;
(
	input  logic    clk_114,
	input  logic    cpu_rst,
	input  logic    c1,
	input  logic    ram_ready,
	input  logic    ram_sel,
	input  cpucfg_t cpucfg,
	output logic    cyc,
	output logic    cpu_ph1,
	output logic    cpu_ph2,
	output logic    ram_cs
);

	logic [`PH_DIV_W-1:0] div;
	logic                 c1_d;      // previous c1
	logic                 c1_rise;
	logic                 fast_cpu;

	assign c1_rise  = c1 & ~c1_d;
	assign fast_cpu = cpucfg[1];

	//////////////////////////////////////////////////
	// free running divider
	//////////////////////////////////////////////////

	always_ff @(posedge clk_114) begin
		c1_d <= c1;
		if (c1_rise) begin
			div <= `PH_DIV_W'd3;   // realign to chipset phase
		end else begin
			div <= div + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// bus strobe and cpu phases
	//////////////////////////////////////////////////

	always_ff @(posedge clk_114) begin
		if (!cpu_rst) begin
			cyc     <= 1'b0;
			cpu_ph1 <= 1'b0;
			cpu_ph2 <= 1'b0;
		end else begin
			cyc <= (div[1:0] == 2'd0);
			if (div[1:0] == 2'd2) begin   // phase boundary
				cpu_ph1 <= 1'b0;
				cpu_ph2 <= 1'b0;
				case (div[3:2])
					2'd0:    cpu_ph2 <= 1'b1;
					2'd2:    cpu_ph1 <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// fast ram select drops once a fast cpu cycle completes
	always_ff @(posedge clk_114) begin
		ram_cs <= ram_sel & ~(ram_ready & cyc & fast_cpu);
	end

endmodule

// ==== hdl/kbd_mouse_sched.sv ====
// presents one controller byte per slot to the chipset keyboard/mouse port
// each type code holds two clk_114 cycles, order after reset is 1, 2, 3, 0
// the data byte follows kms_src live, so fields should be stable per slot

`timescale 1ns/1ns

module kbd_mouse_sched
	import core_pkg::*;
(
	input  logic     clk_114,
	input  logic     cpu_rst,
	input  kms_src_t kms_src,
	output kms_out_t kms_out
);

	kms_out_t  kms_q;      // registered output word
	kms_type_t type_d;     // type delayed by one cycle
	kms_out_t  kms_next;

	//////////////////////////////////////////////////
	// next slot from the delayed type
	//////////////////////////////////////////////////

	// looking at the delayed copy is what stretches each slot to two cycles
	always_comb begin
		case (type_d)
			kms_slot_1: begin
				kms_next.kms_type = kms_slot_2;
				kms_next.data     = kms_src.cont3_joy[31:24];   // rstick_y
				kms_next.level    = 1'b1;
			end
			kms_slot_2: begin
				kms_next.kms_type = kms_slot_3;
				kms_next.data     = kms_src.cont3_key[7:0];     // key bits
				kms_next.level    = 1'b0;
			end
			kms_slot_3: begin
				kms_next.kms_type = kms_slot_0;
				kms_next.data     = kms_src.cont4_joy[7:0];     // lstick_x
				kms_next.level    = 1'b1;
			end
			default: begin
				kms_next.kms_type = kms_slot_1;
				kms_next.data     = kms_src.cont4_trig[7:0];    // ltrig
				kms_next.level    = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_114) begin
		if (!cpu_rst) begin
			kms_q  <= '{data: '0, kms_type: kms_slot_0, level: 1'b0};
			type_d <= kms_slot_0;
		end else begin
			kms_q  <= kms_next;
			type_d <= kms_q.kms_type;   // one cycle behind the output
		end
	end

	assign kms_out = kms_q;

endmodule

// ==== hdl/bridge_read_mux.sv ====
// purely combinational, read data follows the address with no latency
// windows are disjoint, anything outside them reads back zero

`timescale 1ns/1ns

`include "core_params.svh"

module bridge_read_mux
	import core_pkg::*;
(
	input  data32_t        bridge_addr,
	input  bridge_rd_src_t bridge_rd_src,
	output data32_t        bridge_rd_data
);

	logic hit_fpga;   // 0x10xx_xxxx
	logic hit_mcu;    // 0x8000_xxxx
	logic hit_cmd;    // 0xF8xx_xxxx

	// window tags on the top address bits
	assign hit_fpga = (bridge_addr[31:24] == `WIN_FPGA_TAG);
	assign hit_mcu  = (bridge_addr[31:16] == `WIN_MCU_TAG);
	assign hit_cmd  = (bridge_addr[31:24] == `WIN_CMD_TAG);

	always_comb begin
		bridge_rd_data = '0;   // unmapped
		if (hit_fpga) begin
			bridge_rd_data = bridge_rd_src.fpga;
		end else if (hit_mcu) begin
			bridge_rd_data = bridge_rd_src.mcu;
		end else if (hit_cmd) begin
			bridge_rd_data = bridge_rd_src.cmd;
		end
	end

endmodule

// ==== hdl/core_pkg.sv ====
// types shared by the glue blocks and the top level
// struct field order sets the packed bit layout, first field is the msbs

`include "core_params.svh"

package core_pkg;

	//////////////////////////////////////////////////
	// plain vectors
	//////////////////////////////////////////////////

	typedef logic [`CORE_DATA_W-1:0] data32_t;   // bridge addr / data
	typedef logic [`COLOR_W-1:0]     color_t;
	typedef logic [`RGB_W-1:0]       rgb_t;
	typedef logic [`KMS_DATA_W-1:0]  kms_data_t;
	typedef logic [1:0]              res_t;      // chipset resolution
	typedef logic [1:0]              cpucfg_t;   // bit 1 set = fast cpu

	// type code seen by the chipset keyboard/mouse port
	typedef enum logic [1:0] {
		kms_slot_0 = 2'd0,
		kms_slot_1 = 2'd1,
		kms_slot_2 = 2'd2,
		kms_slot_3 = 2'd3
	} kms_type_t;

	//////////////////////////////////////////////////
	// port bundles
	//////////////////////////////////////////////////

	// read data of the three bridge targets, 96 bits
	typedef struct packed {
		data32_t fpga;
		data32_t mcu;
		data32_t cmd;
	} bridge_rd_src_t;

	// controller fields feeding the scheduler, 112 bits
	typedef struct packed {
		data32_t     cont3_key;
		data32_t     cont3_joy;
		data32_t     cont4_joy;
		logic [15:0] cont4_trig;   // ltrig low byte, rtrig high byte
	} kms_src_t;

	// scheduler output, 11 bits
	typedef struct packed {
		kms_data_t data;
		kms_type_t kms_type;
		logic      level;      // field kind flag for the chipset
	} kms_out_t;

	// raw chipset video, 31 bits
	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
		logic   hs;       // active low sync
		logic   vs;       // active low sync
		logic   hblank;
		logic   lace;
		logic   field1;
		res_t   res;
	} video_in_t;

	// scaler video word, 27 bits
	typedef struct packed {
		rgb_t rgb;
		logic de;
		logic vs;
		logic hs;
	} video_out_t;

endpackage

// ==== include/core_params.svh ====
// widths, bridge address window tags and resolution codes for the core glue
// the window tags compare against the top bits of a 32-bit bridge address
// resolution codes are full rgb words sent to the scaler on an hblank edge

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

`define CORE_DATA_W   32   // bridge address and data
`define RGB_W         24   // scaler video bus
`define COLOR_W       8    // one colour channel
`define KMS_DATA_W    8    // keyboard/mouse data byte
`define PH_DIV_W      4    // cpu phase divider

//////////////////////////////////////////////////
// bridge address windows
//////////////////////////////////////////////////

// chipset window, addr[31:24]
`define WIN_FPGA_TAG  8'h10
// mcu substitute window, addr[31:16]
`define WIN_MCU_TAG   16'h8000
// host command window, addr[31:24]
`define WIN_CMD_TAG   8'hF8

//////////////////////////////////////////////////
// scaler resolution words
//////////////////////////////////////////////////

`define RES_CODE_HI   24'h030000   // res 3
`define RES_CODE_MID  24'h020000   // res 2
`define RES_CODE_LO   24'h010000   // res 1

`endif
